// File: compile.f
+incdir+source
+incdir+dv
source/rvIsaPkg.sv
source/rvUopPkg.sv
source/rvOpClassify.sv
source/rvOperandForm.sv
source/rvUopResult.sv
source/rvDecodeTop.sv
dv/rvDecodeTb.sv

// File: dv/rvDecodeTests.svh
/*
 Directed tests of the RISC-V decoder.
 Reference model of the decode rules and one task per behavior.
*/

	// fields in R-type order, other formats fill the same bits
	function automatic logic [31:0] packWord(input logic [6:0] f7, input logic [4:0] rs2, rs1,
			input logic [2:0] f3, input logic [4:0] rd, input rvOpcodeE op);
		return {f7, rs2, rs1, f3, rd, op, 2'b11};
	endfunction

	// expected micro-op from the decode rules, zero means INVOP
	function automatic uopS modelDecode(input logic [31:0] w, input logic user);
		uopS    u;
		subOpT  f3;
		regSelT rd;
		regSelT rs1;
		regSelT rs2;
		immT    immI;
		immT    immU;
		uopCmdE jump;
		uopCmdE aluCmd;
		subOpT  aluSub;
		f3   = subOpT'(w[14:12]);
		rd   = regSelT'(w[11:7]);
		rs1  = regSelT'(w[19:15]);
		rs2  = regSelT'(w[24:20]);
		immI = {{21{w[31]}}, w[31:20]};
		immU = {1'b0, w[31:12], 12'h000};
		jump = (w[11:7] == 5'd0) ? CMD_JMP : CMD_JSR;
		// ALU codes follow funct3 apart from shifts and SUB
		aluCmd = CMD_ALU;
		aluSub = f3;
		if (w[13:12] == 2'b01) begin
			aluCmd = CMD_SHIFT;
			aluSub = !w[14] ? SH_SHL : (w[30] ? SH_SAR : SH_SHR);
		end else if (w[14:12] == 3'd0 && w[5] && w[30]) begin
			aluSub = ALU_SUB;
		end
		u = '0;
		case (w[6:2])
			5'h00: u = '{CMD_LOAD, f3, rd, rs1, REG_IMM, immI};
			5'h08: u = '{CMD_STORE, f3, rs2, rs1, REG_IMM,
					{{21{w[31]}}, w[31:25], w[11:7]}};
			5'h18: u = '{CMD_BRANCH, f3, REG_ZZR, rs1, rs2,
					{{21{w[31]}}, w[7], w[30:25], w[11:8], 1'b0}};
			5'h1b: u = '{jump, 4'd0, rd, REG_PC, REG_IMM,
					{{13{w[31]}}, w[19:12], w[20], w[30:21], 1'b0}};
			5'h19: u = '{jump, 4'd0, rd, rs1, REG_IMM, immI};
			5'h0d: u = '{CMD_MOVIMM, 4'd0, rd, REG_IMM, REG_IMM, immU};
			5'h05: u = '{CMD_LEA, 4'd0, rd, REG_PC, REG_IMM, immU};
			5'h04: u = '{aluCmd, aluSub, rd, rs1, REG_IMM, immI};
			// funct7 of 1 is the multiply group
			5'h0c: if (w[31:25] != 7'h01) u = '{aluCmd, aluSub, rd, rs1, rs2, '0};
			5'h1c: begin
				if (w[19:7] == 13'd0 && w[31:20] == 12'h302)
					u = '{CMD_TRAP, TRAP_RTE, REG_ZZR, REG_ZZR, REG_ZZR, '0};
				else if (w[19:7] == 13'd0 && w[31:21] == 11'd0)
					u = '{CMD_TRAP, subOpT'(w[20]), REG_ZZR, REG_ZZR, REG_ZZR, '0};
			end
			default: u = '0;
		endcase
		if (w[1:0] != 2'b11 || (user && w[11:7] == `RV_TRAP_REG))
			u = '0;
		return u;
	endfunction

	task automatic decodeCheck(input logic [31:0] w, input logic user, input int extra);
		uopS got;
		handshake(w, user, extra, got);
		checkUop($sformatf("word 0x%h", w), got, modelDecode(w, user));
	endtask

	task automatic testReset();
		if (ack !== 1'b0) begin
			$display("ack is not low after reset");
			errors++;
		end
		compareCmd("uop.cmd after reset", uop.cmd, CMD_INVOP);
		compareImm("uop.imm after reset", uop.imm, '0);
		finishTest("reset");
	endtask

	task automatic testAlu();
		int f3;
		for (f3 = 0; f3 < 8; f3++) begin
			// register form, then funct7 bit 5 for sub and sra
			decodeCheck(packWord(7'h00, 5'd7, 5'd9, 3'(f3), 5'd3, OP_OP), 1'b0, 0);
			decodeCheck(packWord(7'h20, 5'd7, 5'd9, 3'(f3), 5'd3, OP_OP), 1'b0, 0);
			// immediate form, negative and positive
			decodeCheck(packWord(7'h7f, 5'h1d, 5'd6, 3'(f3), 5'd5, OP_OPIMM), 1'b0, 0);
			decodeCheck(packWord(7'h20, 5'h02, 5'd6, 3'(f3), 5'd5, OP_OPIMM), 1'b0, 0);
		end
		finishTest("alu and shift");
	endtask

	task automatic testMemJump();
		// lw x8,-8(x2) and lbu x9,36(x3)
		decodeCheck(packWord(7'h7f, 5'h18, 5'd2, 3'd2, 5'd8, OP_LOAD), 1'b0, 0);
		decodeCheck(packWord(7'h01, 5'h04, 5'd3, 3'd4, 5'd9, OP_LOAD), 1'b0, 0);
		// sw x12,-20(x2) and sb x13,81(x3)
		decodeCheck(packWord(7'h7f, 5'd12, 5'd2, 3'd2, 5'h0c, OP_STORE), 1'b0, 0);
		decodeCheck(packWord(7'h02, 5'd13, 5'd3, 3'd0, 5'h11, OP_STORE), 1'b0, 0);
		decodeCheck(packWord(7'h7e, 5'd5, 5'd6, 3'd1, 5'h15, OP_BRANCH), 1'b0, 0);
		decodeCheck(packWord(7'h12, 5'd5, 5'd6, 3'd7, 5'h0a, OP_BRANCH), 1'b0, 0);
		// jal with link, then plain jump
		decodeCheck(packWord(7'h40, 5'h0a, 5'h15, 3'd3, 5'd1, OP_JAL), 1'b0, 0);
		decodeCheck(packWord(7'h05, 5'h13, 5'h02, 3'd6, 5'd0, OP_JAL), 1'b0, 0);
		decodeCheck(packWord(7'h00, 5'd12, 5'd5, 3'd0, 5'd1, OP_JALR), 1'b0, 0);
		decodeCheck(packWord(7'h00, 5'd0, 5'd1, 3'd0, 5'd0, OP_JALR), 1'b0, 0);
		decodeCheck(packWord(7'h5a, 5'h1f, 5'h0c, 3'd5, 5'd7, OP_LUI), 1'b0, 0);
		decodeCheck(packWord(7'h7f, 5'h10, 5'd1, 3'd0, 5'd10, OP_AUIPC), 1'b0, 0);
		finishTest("memory, jump and upper");
	endtask

	task automatic testTrapInvalid();
		logic [31:0] w;
		decodeCheck(packWord(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, OP_SYSTEM), 1'b0, 0);
		decodeCheck(packWord(7'h00, 5'd1, 5'd0, 3'd0, 5'd0, OP_SYSTEM), 1'b0, 0);
		decodeCheck(packWord(7'h18, 5'd2, 5'd0, 3'd0, 5'd0, OP_SYSTEM), 1'b0, 0);
		// csr form of SYSTEM is not a trap
		decodeCheck(packWord(7'h18, 5'd2, 5'd0, 3'd1, 5'd5, OP_SYSTEM), 1'b0, 0);
		// addi in quadrants 0 and 2
		decodeCheck(packWord(7'h00, 5'd8, 5'd2, 3'd0, 5'd9, OP_OPIMM) & ~32'h3, 1'b0, 0);
		decodeCheck(packWord(7'h00, 5'd8, 5'd2, 3'd0, 5'd9, OP_OPIMM) ^ 32'h1, 1'b0, 0);
		// mul and div
		decodeCheck(packWord(7'h01, 5'd7, 5'd9, 3'd0, 5'd3, OP_OP), 1'b0, 0);
		decodeCheck(packWord(7'h01, 5'd7, 5'd9, 3'd4, 5'd3, OP_OP), 1'b0, 0);
		repeat (8) begin
			w = nextRandom();
			while (w[6:2] inside {5'h00, 5'h04, 5'h05, 5'h08, 5'h0c, 5'h0d, 5'h18,
					5'h19, 5'h1b, 5'h1c})
				w = nextRandom();
			w[1:0] = 2'b11;
			decodeCheck(w, 1'b0, 0);
		end
		finishTest("trap and invalid");
	endtask

	task automatic testUserReject();
		// each x4 write in user mode, then in supervisor mode
		decodeCheck(packWord(7'h00, 5'd5, 5'd6, 3'd0, 5'd4, OP_OPIMM), 1'b1, 0);
		decodeCheck(packWord(7'h00, 5'd5, 5'd6, 3'd0, 5'd4, OP_OPIMM), 1'b0, 0);
		decodeCheck(packWord(7'h12, 5'h0f, 5'd1, 3'd3, 5'd4, OP_LUI), 1'b1, 0);
		decodeCheck(packWord(7'h12, 5'h0f, 5'd1, 3'd3, 5'd4, OP_LUI), 1'b0, 0);
		decodeCheck(packWord(7'h00, 5'd8, 5'd2, 3'd2, 5'd4, OP_LOAD), 1'b1, 0);
		decodeCheck(packWord(7'h00, 5'd8, 5'd2, 3'd2, 5'd4, OP_LOAD), 1'b0, 0);
		decodeCheck(packWord(7'h00, 5'h10, 5'd0, 3'd0, 5'd4, OP_JAL), 1'b1, 0);
		decodeCheck(packWord(7'h00, 5'h10, 5'd0, 3'd0, 5'd4, OP_JAL), 1'b0, 0);
		// other destinations pass in user mode
		decodeCheck(packWord(7'h00, 5'd5, 5'd6, 3'd0, 5'd5, OP_OPIMM), 1'b1, 0);
		finishTest("user mode x4 reject");
	endtask

	task automatic testHold();
		logic [31:0] w;
		int          extra;
		repeat (6) begin
			w = nextRandom();
			w[6:0] = {OP_OPIMM, 2'b11};
			extra = 1 + int'(nextRandom() % 32'd10);
			decodeCheck(w, 1'b0, extra);
		end
		finishTest("req held after ack");
	endtask

// File: dv/rvDecodeTb.sv
/*
 Testbench for the RISC-V decoder.
 Drives one instruction word per req/ack handshake, checks the
 micro-op against a reference model and reports one line per test.
*/
`timescale 1ns/1ps
`include "rvDec_config.svh"

module rvDecodeTb;
	import rvIsaPkg::*;
	import rvUopPkg::*;

	localparam int CLOCK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	// alu, memory and jump, trap and invalid, user mode, hold
	localparam int HANDSHAKES = 32 + 12 + 16 + 9 + 6;

	logic        clock;
	logic        arstN;
	logic        req;
	rvInstrS     instr;
	logic        userMode;
	logic        ack;
	uopS         uop;
	int          errors;
	int          testStart;
	int          testsRun;
	int          testsFailed;
	logic [31:0] rngState;

	rvDecodeTop u_dut (.*);

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// xorshift32
	function automatic logic [31:0] nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	task automatic reportMismatch(input string name, input logic [63:0] got, exp);
		$display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
		errors++;
	endtask

	task automatic compareCmd(input string name, input uopCmdE got, exp);
		if (got !== exp)
			reportMismatch(name, got, exp);
	endtask

	task automatic compareSubOp(input string name, input subOpT got, exp);
		if (got !== exp)
			reportMismatch(name, got, exp);
	endtask

	task automatic compareReg(input string name, input regSelT got, exp);
		if (got !== exp)
			reportMismatch(name, got, exp);
	endtask

	task automatic compareImm(input string name, input immT got, exp);
		if (got !== exp)
			reportMismatch(name, got, exp);
	endtask

	task automatic checkUop(input string tag, input uopS got, exp);
		compareCmd({"uop.cmd ", tag}, got.cmd, exp.cmd);
		compareSubOp({"uop.subOp ", tag}, got.subOp, exp.subOp);
		compareReg({"uop.regN ", tag}, got.regN, exp.regN);
		compareReg({"uop.regM ", tag}, got.regM, exp.regM);
		compareReg({"uop.regO ", tag}, got.regO, exp.regO);
		compareImm({"uop.imm ", tag}, got.imm, exp.imm);
	endtask

	// full four-phase transfer, req kept high for extra cycles after ack
	task automatic handshake(input logic [31:0] w, input logic user, input int extra,
			output uopS got);
		int edges;
		edges = 0;
		@(negedge clock);
		instr = rvInstrS'(w);
		userMode = user;
		req = 1'b1;
		while (!ack && edges < 10) begin
			@(negedge clock);
			edges++;
		end
		if (!ack) begin
			$display("no ack within 10 cycles of req for word 0x%h", w);
			errors++;
		end else if (edges != 2) begin
			$display("ack came %0d cycles after req instead of 2 for word 0x%h", edges, w);
			errors++;
		end
		got = uop;
		repeat (extra) begin
			@(negedge clock);
			if (!ack) begin
				$display("ack dropped while req was still high for word 0x%h", w);
				errors++;
			end
			checkUop("while held", uop, got);
		end
		req = 1'b0;
		edges = 0;
		while (ack && edges < 10) begin
			@(negedge clock);
			edges++;
		end
		if (edges != 1) begin
			$display("ack fell %0d cycles after req dropped instead of 1", edges);
			errors++;
		end
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errors == testStart) begin
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", name, errors - testStart);
		end
		testStart = errors;
	endtask

	`include "rvDecodeTests.svh"

	initial begin
		clock = 1'b0;
		arstN = 1'b0;
		req = 1'b0;
		instr = '0;
		userMode = 1'b0;
		errors = 0;
		testStart = 0;
		testsRun = 0;
		testsFailed = 0;
		rngState = 32'd25375;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
		testReset();
		testAlu();
		testMemJump();
		testTrapInvalid();
		testUserReject();
		testHold();
		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// 50 cycles per handshake on top of reset
	initial begin
		#((RESET_CYCLES + HANDSHAKES * 50) * CLOCK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: source/rvDec_config.svh
/*
 RISC-V decoder configuration.
 Widths of the instruction word, register selectors, immediate and
 sub-op fields, plus the register that user mode may not write.
*/
`ifndef RV_DEC_CONFIG_SVH
`define RV_DEC_CONFIG_SVH

// base-integer instruction word
`define RV_INSTR_W 32

// selector: 0..31 are GPRs, above that special sources
`define RV_REG_W 6

// immediate carried in the micro-op, bit 32 holds the sign
`define RV_IMM_W 33

// sub-operation field of the micro-op
`define RV_SUBOP_W 4

// destination rejected in user mode
`define RV_TRAP_REG 4

`endif

// File: source/rvDecodeTop.sv
/*
 RISC-V instruction decoder top level.
 Takes one 32-bit word per req/ack handshake and returns a micro-op
 built by the decode, execute and result stages.
*/
`timescale 1ns/1ps

module rvDecodeTop (
	input  logic              clock,
	input  logic              arstN,
	input  logic              req,
	input  rvIsaPkg::rvInstrS instr,
	input  logic              userMode,
	output logic              ack,
	output rvUopPkg::uopS     uop
);
	import rvIsaPkg::*;
	import rvUopPkg::*;

	logic    take;
	logic    userReg;
	rvInstrS fields;
	classS   cls;
	uopS     uopNext;

	rvOpClassify u_classify (
		.clock    (clock),
		.arstN    (arstN),
		.take     (take),
		.instr    (instr),
		.userMode (userMode),
		.fields   (fields),
		.userReg  (userReg),
		.cls      (cls)
	);

	rvOperandForm u_operand (
		.fields  (fields),
		.userReg (userReg),
		.cls     (cls),
		.uopNext (uopNext)
	);

	rvUopResult u_result (
		.clock   (clock),
		.arstN   (arstN),
		.req     (req),
		.uopNext (uopNext),
		.take    (take),
		.ack     (ack),
		.uop     (uop)
	);

endmodule

// File: source/rvIsaPkg.sv
/*
 RISC-V encoding types.
 Major opcode and funct3 encodings of the base integer set and a
 packed field view of a 32-bit instruction word.
*/
package rvIsaPkg;

	// instruction bits 6:2
	typedef enum logic [4:0] {
		OP_LOAD   = 5'b00000,
		OP_OPIMM  = 5'b00100,
		OP_AUIPC  = 5'b00101,
		OP_STORE  = 5'b01000,
		OP_OP     = 5'b01100,
		OP_LUI    = 5'b01101,
		OP_BRANCH = 5'b11000,
		OP_JALR   = 5'b11001,
		OP_JAL    = 5'b11011,
		OP_SYSTEM = 5'b11100
	} rvOpcodeE;

	// conditional branch compare
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} rvBranchF3E;

	// register and immediate ALU forms share these
	typedef enum logic [2:0] {
		F3_ADD  = 3'b000,
		F3_SLL  = 3'b001,
		F3_SLT  = 3'b010,
		F3_SLTU = 3'b011,
		F3_XOR  = 3'b100,
		F3_SR   = 3'b101,
		F3_OR   = 3'b110,
		F3_AND  = 3'b111
	} rvAluF3E;

	// R-type layout, other formats reuse the bits
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		rvOpcodeE   opcode;
		// 2'b11 for all 32-bit encodings
		logic [1:0] quadrant;
	} rvInstrS;

endpackage

// File: source/rvOpClassify.sv
/*
 Decode stage of the RISC-V decoder.
 Captures the instruction word and mode on take, then maps opcode,
 funct3 and funct7 to a micro-op command and sub-op.
*/
`timescale 1ns/1ps

module rvOpClassify (
	input  logic              clock,
	input  logic              arstN,
	input  logic              take,
	input  rvIsaPkg::rvInstrS instr,
	input  logic              userMode,
	output rvIsaPkg::rvInstrS fields,
	output logic              userReg,
	output rvUopPkg::classS   cls
);
	import rvIsaPkg::*;
	import rvUopPkg::*;

	uopCmdE     cmd;
	subOpT      subOp;
	logic       known;
	rvAluF3E    aluF3;
	rvBranchF3E brCond;

	// cleared word has quadrant 0 and so reads as INVOP
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			fields  <= '0;
			userReg <= 1'b0;
		end else if (take) begin
			fields  <= instr;
			userReg <= userMode;
		end
	end

	assign aluF3  = rvAluF3E'(fields.funct3);
	assign brCond = rvBranchF3E'(fields.funct3);

	always_comb begin
		cmd   = CMD_INVOP;
		subOp = '0;
		known = 1'b1;
		case (fields.opcode)
			OP_LOAD: begin
				cmd   = CMD_LOAD;
				subOp = subOpT'(fields.funct3);
			end
			OP_STORE: begin
				cmd   = CMD_STORE;
				subOp = subOpT'(fields.funct3);
			end
			OP_BRANCH: begin
				cmd   = CMD_BRANCH;
				subOp = subOpT'(brCond);
			end
			// link to x0 is a plain jump
			OP_JAL, OP_JALR: cmd = (fields.rd == 5'd0) ? CMD_JMP : CMD_JSR;
			OP_LUI:   cmd = CMD_MOVIMM;
			OP_AUIPC: cmd = CMD_LEA;
			OP_OPIMM, OP_OP: begin
				cmd = CMD_ALU;
				case (aluF3)
					F3_ADD: begin
						// only the register form has SUB
						if (fields.opcode == OP_OP && fields.funct7[5])
							subOp = ALU_SUB;
						else
							subOp = ALU_ADD;
					end
					F3_SLL: begin
						cmd   = CMD_SHIFT;
						subOp = SH_SHL;
					end
					F3_SLT:  subOp = ALU_SLT;
					F3_SLTU: subOp = ALU_SLTU;
					F3_XOR:  subOp = ALU_XOR;
					F3_SR: begin
						cmd   = CMD_SHIFT;
						subOp = fields.funct7[5] ? SH_SAR : SH_SHR;
					end
					F3_OR:  subOp = ALU_OR;
					F3_AND: subOp = ALU_AND;
				endcase
				// multiply/divide group is not supported
				if (fields.opcode == OP_OP && fields.funct7 == 7'h01)
					known = 1'b0;
			end
			OP_SYSTEM: begin
				cmd = CMD_TRAP;
				if (fields.funct3 != 3'd0 || fields.rs1 != 5'd0 || fields.rd != 5'd0)
					known = 1'b0;
				case ({fields.funct7, fields.rs2})
					12'h000: subOp = TRAP_SYSE;
					12'h001: subOp = TRAP_BREAK;
					12'h302: subOp = TRAP_RTE;
					default: known = 1'b0;
				endcase
			end
			default: known = 1'b0;
		endcase
		// compressed quadrants are not decoded here
		if (fields.quadrant != 2'b11)
			known = 1'b0;
		if (!known) begin
			cmd   = CMD_INVOP;
			subOp = '0;
		end
	end

	assign cls = '{cmd: cmd, subOp: subOp, illegal: !known};

	// command always holds a defined encoding
	assert property (@(posedge clock) disable iff (!arstN)
		cls.cmd inside {[CMD_INVOP:CMD_TRAP]});

endmodule

// File: source/rvOperandForm.sv
/*
 Execute stage of the RISC-V decoder.
 Forms the immediate and the three register selectors from the
 command and the captured word, and rejects user writes to x4.
*/
`timescale 1ns/1ps
`include "rvDec_config.svh"

module rvOperandForm (
	input  rvIsaPkg::rvInstrS fields,
	input  logic              userReg,
	input  rvUopPkg::classS   cls,
	output rvUopPkg::uopS     uopNext
);
	import rvIsaPkg::*;
	import rvUopPkg::*;

	logic [`RV_INSTR_W-1:0] word;
	logic                   sign;
	immT                    immI;
	immT                    immS;
	immT                    immB;
	immT                    immJ;
	immT                    immU;
	regSelT                 selRd;
	regSelT                 selRs1;
	regSelT                 selRs2;
	logic                   isJal;
	logic                   isImmAlu;
	logic                   reject;

	assign word = fields;
	assign sign = word[`RV_INSTR_W-1];

	// sign-extended to 33 bits
	assign immI = {{21{sign}}, word[31:20]};
	assign immS = {{21{sign}}, word[31:25], word[11:7]};
	assign immB = {{21{sign}}, word[7], word[30:25], word[11:8], 1'b0};
	assign immJ = {{13{sign}}, word[19:12], word[20], word[30:21], 1'b0};
	// upper immediate stays unsigned
	assign immU = {1'b0, word[31:12], 12'h000};

	assign selRd  = regSelT'(fields.rd);
	assign selRs1 = regSelT'(fields.rs1);
	assign selRs2 = regSelT'(fields.rs2);

	assign isJal    = (fields.opcode == OP_JAL);
	assign isImmAlu = (fields.opcode == OP_OPIMM);
	assign reject   = userReg && (fields.rd == `RV_TRAP_REG);

	always_comb begin
		uopNext.cmd   = cls.cmd;
		uopNext.subOp = cls.subOp;
		uopNext.regN  = selRd;
		uopNext.regM  = selRs1;
		uopNext.regO  = selRs2;
		uopNext.imm   = '0;
		case (cls.cmd)
			CMD_LOAD: begin
				uopNext.imm  = immI;
				uopNext.regO = REG_IMM;
			end
			CMD_STORE: begin
				// store data goes out on N
				uopNext.imm  = immS;
				uopNext.regO = REG_IMM;
				uopNext.regN = selRs2;
			end
			CMD_BRANCH: begin
				uopNext.imm  = immB;
				uopNext.regN = REG_ZZR;
			end
			CMD_JMP, CMD_JSR: begin
				uopNext.regO = REG_IMM;
				if (isJal) begin
					uopNext.imm  = immJ;
					uopNext.regM = REG_PC;
				end else begin
					uopNext.imm = immI;
				end
			end
			CMD_ALU, CMD_SHIFT: begin
				if (isImmAlu) begin
					uopNext.imm  = immI;
					uopNext.regO = REG_IMM;
				end
			end
			CMD_LEA: begin
				uopNext.imm  = immU;
				uopNext.regM = REG_PC;
				uopNext.regO = REG_IMM;
			end
			CMD_MOVIMM: begin
				uopNext.imm  = immU;
				uopNext.regM = REG_IMM;
				uopNext.regO = REG_IMM;
			end
			default: begin
				// traps and invalid ops carry no operands
				uopNext.regN = REG_ZZR;
				uopNext.regM = REG_ZZR;
				uopNext.regO = REG_ZZR;
			end
		endcase
		if (cls.illegal || reject) begin
			uopNext.cmd   = CMD_INVOP;
			uopNext.subOp = '0;
			uopNext.regN  = REG_ZZR;
			uopNext.regM  = REG_ZZR;
			uopNext.regO  = REG_ZZR;
			uopNext.imm   = '0;
		end
	end

endmodule

// File: source/rvUopPkg.sv
/*
 Micro-op types.
 Command set, sub-op codes and register selector codes of the
 decoded micro-op, and the structs passed between decode stages.
*/
`include "rvDec_config.svh"

package rvUopPkg;

	typedef enum logic [3:0] {
		CMD_INVOP  = 4'd0,
		CMD_LOAD   = 4'd1,
		CMD_STORE  = 4'd2,
		CMD_BRANCH = 4'd3,
		CMD_JMP    = 4'd4,
		CMD_JSR    = 4'd5,
		CMD_ALU    = 4'd6,
		CMD_SHIFT  = 4'd7,
		CMD_LEA    = 4'd8,
		CMD_MOVIMM = 4'd9,
		CMD_TRAP   = 4'd10
	} uopCmdE;

	typedef logic [`RV_SUBOP_W-1:0] subOpT;
	typedef logic [`RV_REG_W-1:0] regSelT;
	typedef logic [`RV_IMM_W-1:0] immT;

	// ALU sub-ops
	localparam subOpT ALU_ADD  = 4'd0;
	localparam subOpT ALU_SUB  = 4'd1;
	localparam subOpT ALU_SLT  = 4'd2;
	localparam subOpT ALU_SLTU = 4'd3;
	localparam subOpT ALU_XOR  = 4'd4;
	localparam subOpT ALU_OR   = 4'd6;
	localparam subOpT ALU_AND  = 4'd7;

	// shifter sub-ops
	localparam subOpT SH_SHL = 4'd0;
	localparam subOpT SH_SHR = 4'd1;
	localparam subOpT SH_SAR = 4'd2;

	// trap kinds: ecall, ebreak, mret
	localparam subOpT TRAP_SYSE  = 4'd0;
	localparam subOpT TRAP_BREAK = 4'd1;
	localparam subOpT TRAP_RTE   = 4'd2;

	// special selectors above the 32 GPRs
	localparam regSelT REG_ZZR = 6'd0;
	localparam regSelT REG_IMM = 6'd32;
	localparam regSelT REG_PC  = 6'd33;

	// classify result, 9 bits
	typedef struct packed {
		uopCmdE cmd;
		subOpT  subOp;
		logic   illegal;
	} classS;

	typedef struct packed {
		uopCmdE cmd;
		subOpT  subOp;
		regSelT regN;
		regSelT regM;
		regSelT regO;
		immT    imm;
	} uopS;

endpackage

// File: source/rvUopResult.sv
/*
 Result stage of the RISC-V decoder.
 Four-phase req/ack handshake FSM; requests a capture, then holds
 the registered micro-op and ack until req drops.
*/
`timescale 1ns/1ps

module rvUopResult (
	input  logic          clock,
	input  logic          arstN,
	input  logic          req,
	input  rvUopPkg::uopS uopNext,
	output logic          take,
	output logic          ack,
	output rvUopPkg::uopS uop
);
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		FORM = 2'd1,
		HOLD = 2'd2
	} stateE;

	stateE state;
	stateE stateNext;

	always_comb begin
		stateNext = state;
		case (state)
			IDLE: if (req) stateNext = FORM;
			FORM: stateNext = HOLD;
			HOLD: if (!req) stateNext = IDLE;
			default: stateNext = IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			state <= IDLE;
		else
			state <= stateNext;
	end

	// capture pulse for the word classified during FORM
	assign take = (state == IDLE) && req;
	assign ack  = (state == HOLD);

	// zero after reset reads as INVOP
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			uop <= '0;
		else if (state == FORM)
			uop <= uopNext;
	end

	// ack only answers a request that was already up
	assert property (@(posedge clock) disable iff (!arstN)
		$rose(ack) |-> $past(req));

	// requester sees a steady micro-op for the whole ack phase
	assert property (@(posedge clock) disable iff (!arstN)
		ack && $past(ack) |-> $stable(uop));

endmodule
